// File: source/ex_data_pkg.sv
// Execute stage datapath types

package ex_data_pkg;

  ////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////

  // Operand, result, CSR and load data word
  typedef logic [31:0] word_t;

  // Register file address, 32 registers
  typedef logic [4:0] reg_addr_t;

endpackage

// File: source/ex_ops_pkg.sv
// Execute stage operator encodings

package ex_ops_pkg;

  ////////////////////////////////////////
  // ALU operators
  ////////////////////////////////////////

  // Explicit codes keep the decode side and the stimulus files stable
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    // Shift amount is operand b [4:0]
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    // Set-less-than, result is the zero-extended flag
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    // Branch comparisons, drive the branch flag
    ALU_EQ   = 4'ha,
    ALU_NE   = 4'hb,
    ALU_LT   = 4'hc,
    ALU_GE   = 4'hd,
    ALU_LTU  = 4'he,
    ALU_GEU  = 4'hf
  } alu_op_e;

  ////////////////////////////////////////
  // Multiplier operators and sequencing
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    MUL    = 2'd0,
    MULH   = 2'd1,
    MULHSU = 2'd2,
    MULHU  = 2'd3
  } mult_op_e;

  // High product sequence, one partial product per step
  typedef enum logic [1:0] {
    MULT_IDLE = 2'd0,
    MULT_PART = 2'd1,
    MULT_DONE = 2'd2
  } mult_state_e;

endpackage

// File: source/ex_alu.sv
// Integer ALU
`timescale 1ns/1ps

module ex_alu (
  input  ex_ops_pkg::alu_op_e operator_i,
  input  ex_data_pkg::word_t  operand_a_i,
  input  ex_data_pkg::word_t  operand_b_i,
  output ex_data_pkg::word_t  result_o,
  output logic                comparison_result_o
);

  import ex_data_pkg::*;
  import ex_ops_pkg::*;

  logic        cmp_signed;
  logic [32:0] sub_a;
  logic [32:0] sub_b;
  logic [32:0] difference;
  logic        is_equal;
  logic        is_less;
  logic        cmp_flag;
  logic [4:0]  shamt;
  logic        shift_fill;
  logic [32:0] shift_ext;
  word_t       sum;
  word_t       shift_left;
  word_t       shift_right;

  ////////////////////////////////////////
  // Shared subtractor
  ////////////////////////////////////////

  // Signed compares extend with the sign bit, unsigned with zero
  always_comb begin
    case (operator_i)
      ALU_SLT, ALU_LT, ALU_GE: cmp_signed = 1'b1;
      default:                 cmp_signed = 1'b0;
    endcase
  end

  assign sub_a = {cmp_signed & operand_a_i[31], operand_a_i};
  assign sub_b = {cmp_signed & operand_b_i[31], operand_b_i};

  // 33 bits hold any difference, so bit 32 is the true sign
  assign difference = sub_a - sub_b;
  assign is_less    = difference[32];
  // Low word is zero only for equal operands
  assign is_equal   = (difference[31:0] == '0);

  assign sum = operand_a_i + operand_b_i;

  ////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////

  assign shamt      = operand_b_i[4:0];
  assign shift_left = operand_a_i << shamt;

  // One right shifter, the fill bit selects arithmetic or logical
  assign shift_fill  = (operator_i == ALU_SRA) & operand_a_i[31];
  assign shift_ext   = $signed({shift_fill, operand_a_i}) >>> shamt;
  assign shift_right = shift_ext[31:0];

  // Branch flag, low for everything but the six comparisons
  always_comb begin
    case (operator_i)
      ALU_EQ:           cmp_flag = is_equal;
      ALU_NE:           cmp_flag = ~is_equal;
      ALU_LT, ALU_LTU:  cmp_flag = is_less;
      ALU_GE, ALU_GEU:  cmp_flag = ~is_less;
      default:          cmp_flag = 1'b0;
    endcase
  end

  // Result select
  always_comb begin
    case (operator_i)
      ALU_ADD:            result_o = sum;
      ALU_SUB:            result_o = difference[31:0];
      ALU_AND:            result_o = operand_a_i & operand_b_i;
      ALU_OR:             result_o = operand_a_i | operand_b_i;
      ALU_XOR:            result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:            result_o = shift_left;
      ALU_SRL, ALU_SRA:   result_o = shift_right;
      ALU_SLT, ALU_SLTU:  result_o = {31'b0, is_less};
      default:            result_o = {31'b0, cmp_flag};
    endcase
  end

  assign comparison_result_o = cmp_flag;

endmodule

// File: source/ex_mult.sv
// Integer multiplier
`timescale 1ns/1ps

module ex_mult (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 enable_i,
  input  ex_ops_pkg::mult_op_e operator_i,
  input  ex_data_pkg::word_t   op_a_i,
  input  ex_data_pkg::word_t   op_b_i,

  // Stage advance strobe
  input  logic                 ex_ready_i,

  output ex_data_pkg::word_t   result_o,
  output logic                 multicycle_o,
  output logic                 ready_o
);

  import ex_data_pkg::*;
  import ex_ops_pkg::*;

  mult_state_e        state_q;
  mult_state_e        state_d;
  logic               high_op;
  logic               start_high;
  logic               sign_a;
  logic               sign_b;
  logic [32:0]        a_ext;
  logic [32:0]        b_ext;
  logic [16:0]        b_slice;
  logic signed [49:0] partial;
  logic [63:0]        partial_ext;
  logic [63:0]        acc_q;
  word_t              low_product;

  ////////////////////////////////////////
  // Low product
  ////////////////////////////////////////

  // Low word does not depend on operand signedness
  assign low_product = op_a_i * op_b_i;

  ////////////////////////////////////////
  // High product datapath
  ////////////////////////////////////////

  assign high_op    = (operator_i != MUL);
  assign start_high = enable_i & high_op;

  // MULH signed x signed, MULHSU signed x unsigned, MULHU unsigned
  assign sign_a = (operator_i == MULH) | (operator_i == MULHSU);
  assign sign_b = (operator_i == MULH);

  assign a_ext = {sign_a & op_a_i[31], op_a_i};
  assign b_ext = {sign_b & op_b_i[31], op_b_i};

  // Lower half of b first, as a positive 17-bit value
  // Upper half in MULT_PART, carries the extension bit
  assign b_slice = (state_q == MULT_PART) ? b_ext[32:16] : {1'b0, op_b_i[15:0]};

  // One 33 x 17 signed multiplier used by both steps
  assign partial     = $signed({{17{a_ext[32]}}, a_ext}) *
                       $signed({{33{b_slice[16]}}, b_slice});
  assign partial_ext = {{14{partial[49]}}, partial};

  // Accumulator only needs the 64 product bits
  always_ff @(posedge clk) begin
    if (state_q == MULT_IDLE) begin
      if (start_high) begin
        acc_q <= partial_ext;
      end
    end else if (state_q == MULT_PART) begin
      acc_q <= acc_q + {partial_ext[47:0], 16'h0000};
    end
  end

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      MULT_IDLE: begin
        if (start_high) begin
          state_d = MULT_PART;
        end
      end
      MULT_PART: begin
        state_d = MULT_DONE;
      end
      MULT_DONE: begin
        // Result waits here while writeback stalls
        if (ex_ready_i) begin
          state_d = MULT_IDLE;
        end
      end
      default: begin
        state_d = MULT_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Low only from the issue cycle through MULT_PART
  assign ready_o = (state_q == MULT_DONE) | ((state_q == MULT_IDLE) & ~start_high);

  assign multicycle_o = (state_q != MULT_IDLE);

  // Upper word of the accumulator is valid in MULT_DONE
  assign result_o = high_op ? acc_q[63:32] : low_product;

endmodule

// File: source/ex_writeback.sv
// Execute stage writeback
`timescale 1ns/1ps

module ex_writeback (
  input  logic                   clk,
  input  logic                   rst_n,

  // Unit enables
  input  logic                   alu_en_i,
  input  logic                   mult_en_i,
  input  logic                   csr_access_i,
  input  logic                   lsu_en_i,

  // Unit results
  input  ex_data_pkg::word_t     alu_result_i,
  input  ex_data_pkg::word_t     mult_result_i,
  input  ex_data_pkg::word_t     csr_rdata_i,
  input  ex_data_pkg::word_t     lsu_rdata_i,
  input  logic                   alu_cmp_result_i,
  input  ex_data_pkg::word_t     alu_operand_c_i,

  // Write port requests from decode
  input  logic                   regfile_alu_we_i,
  input  ex_data_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic                   regfile_we_i,
  input  ex_data_pkg::reg_addr_t regfile_waddr_i,

  // Stall sources
  input  logic                   mult_ready_i,
  input  logic                   lsu_ready_ex_i,
  input  logic                   lsu_err_i,
  input  logic                   branch_in_ex_i,
  input  logic                   wb_ready_i,

  // Forwarding port
  output logic                   regfile_alu_we_fw_o,
  output ex_data_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output ex_data_pkg::word_t     regfile_alu_wdata_fw_o,

  // LSU port after the EX/WB register
  output logic                   regfile_we_wb_o,
  output ex_data_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_data_pkg::word_t     regfile_wdata_wb_o,

  output logic                   branch_decision_o,
  output ex_data_pkg::word_t     jump_target_o,

  output logic                   ex_ready_o,
  output logic                   ex_valid_o
);

  import ex_data_pkg::*;

  logic      units_ready;
  logic      ex_valid;
  logic      lsu_we_next;
  logic      regfile_we_lsu;
  reg_addr_t regfile_waddr_lsu;

  ////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////

  // CSR read data wins, then multiplier, then ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // Branch target comes in on operand c
  assign branch_decision_o = alu_cmp_result_i;
  assign jump_target_o     = alu_operand_c_i;

  ////////////////////////////////////////
  // Stage strobes
  ////////////////////////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches finish in EX and need no writeback slot
  assign ex_ready_o = units_ready | branch_in_ex_i;

  assign ex_valid   = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;
  assign ex_valid_o = ex_valid;

  ////////////////////////////////////////
  // EX/WB register, LSU port
  ////////////////////////////////////////

  // A faulting load never reaches the register file
  assign lsu_we_next = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_lsu <= 1'b0;
    end else if (ex_valid) begin
      regfile_we_lsu <= lsu_we_next;
    end else if (wb_ready_i) begin
      // Nothing new from EX, drain the slot
      regfile_we_lsu <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid && lsu_we_next) begin
      regfile_waddr_lsu <= regfile_waddr_i;
    end
  end

  assign regfile_we_wb_o    = regfile_we_lsu;
  assign regfile_waddr_wb_o = regfile_waddr_lsu;
  // Load data already arrives aligned with the WB cycle
  assign regfile_wdata_wb_o = lsu_rdata_i;

endmodule

// File: source/ex_stage_top.sv
// Integer execute stage
`timescale 1ns/1ps

module ex_stage_top (
  input  logic                   clk,
  input  logic                   rst_n,

  // ALU operation
  input  logic                   alu_en_i,
  input  ex_ops_pkg::alu_op_e    alu_operator_i,
  input  ex_data_pkg::word_t     alu_operand_a_i,
  input  ex_data_pkg::word_t     alu_operand_b_i,
  input  ex_data_pkg::word_t     alu_operand_c_i,

  // Multiplier operation
  input  logic                   mult_en_i,
  input  ex_ops_pkg::mult_op_e   mult_operator_i,
  input  ex_data_pkg::word_t     mult_operand_a_i,
  input  ex_data_pkg::word_t     mult_operand_b_i,

  // CSR read
  input  logic                   csr_access_i,
  input  ex_data_pkg::word_t     csr_rdata_i,

  // Forwarding port request
  input  logic                   regfile_alu_we_i,
  input  ex_data_pkg::reg_addr_t regfile_alu_waddr_i,

  // LSU port request and load data
  input  logic                   regfile_we_i,
  input  ex_data_pkg::reg_addr_t regfile_waddr_i,
  input  logic                   lsu_en_i,
  input  ex_data_pkg::word_t     lsu_rdata_i,
  input  logic                   lsu_ready_ex_i,
  input  logic                   lsu_err_i,

  input  logic                   branch_in_ex_i,
  input  logic                   wb_ready_i,

  // Forwarding port to register file and decode
  output logic                   regfile_alu_we_fw_o,
  output ex_data_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output ex_data_pkg::word_t     regfile_alu_wdata_fw_o,

  // LSU port to register file
  output logic                   regfile_we_wb_o,
  output ex_data_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_data_pkg::word_t     regfile_wdata_wb_o,

  // To fetch
  output logic                   branch_decision_o,
  output ex_data_pkg::word_t     jump_target_o,

  output logic                   mult_multicycle_o,
  output logic                   ex_ready_o,
  output logic                   ex_valid_o
);

  import ex_data_pkg::*;

  word_t alu_result;
  logic  alu_cmp_result;
  word_t mult_result;
  logic  mult_ready;

  ////////////////////////////////////////
  // Execution units
  ////////////////////////////////////////

  ex_alu u_alu (
    .operator_i          (alu_operator_i),
    .operand_a_i         (alu_operand_a_i),
    .operand_b_i         (alu_operand_b_i),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp_result)
  );

  // Advances out of MULT_DONE with the stage
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ////////////////////////////////////////
  // Write ports and strobes
  ////////////////////////////////////////

  ex_writeback u_writeback (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .alu_cmp_result_i       (alu_cmp_result),
    .alu_operand_c_i        (alu_operand_c_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .mult_ready_i           (mult_ready),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .wb_ready_i             (wb_ready_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .branch_decision_o      (branch_decision_o),
    .jump_target_o          (jump_target_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

// File: verif/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset held for 8 cycles, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// File: verif/tb_ex_stage.sv
// Execute stage testbench
`timescale 1ns/1ps

module tb_ex_stage;

  import ex_data_pkg::*;
  import ex_ops_pkg::*;

  localparam int FIELDS      = 11;
  localparam int MAX_VECTORS = 48;
  localparam int READY_LIMIT = 20;
  localparam int RESET_LIMIT = 32;

  logic      clk;
  logic      rst_n;
  logic      alu_en_i;
  alu_op_e   alu_operator_i;
  word_t     alu_operand_a_i;
  word_t     alu_operand_b_i;
  word_t     alu_operand_c_i;
  logic      mult_en_i;
  mult_op_e  mult_operator_i;
  word_t     mult_operand_a_i;
  word_t     mult_operand_b_i;
  logic      csr_access_i;
  word_t     csr_rdata_i;
  logic      regfile_alu_we_i;
  reg_addr_t regfile_alu_waddr_i;
  logic      regfile_we_i;
  reg_addr_t regfile_waddr_i;
  logic      lsu_en_i;
  word_t     lsu_rdata_i;
  logic      lsu_ready_ex_i;
  logic      lsu_err_i;
  logic      branch_in_ex_i;
  logic      wb_ready_i;
  logic      regfile_alu_we_fw_o;
  reg_addr_t regfile_alu_waddr_fw_o;
  word_t     regfile_alu_wdata_fw_o;
  logic      regfile_we_wb_o;
  reg_addr_t regfile_waddr_wb_o;
  word_t     regfile_wdata_wb_o;
  logic      branch_decision_o;
  word_t     jump_target_o;
  logic      mult_multicycle_o;
  logic      ex_ready_o;
  logic      ex_valid_o;

  // Flat vector storage, FIELDS words per operation
  logic [31:0] vec_mem [0:FIELDS*MAX_VECTORS-1];
  integer      seed;
  int          errors;
  int          checks;
  int          timeouts;
  int          vec_count;

  tb_clock_gen clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ex_stage_top dut (.*);

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t: vector %0d, %s is %h, expected %h", $time, vec_count, what, got, exp);
    end
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (rst_n !== 1'b1) begin
      if (n == RESET_LIMIT) begin
        $display("Timeout: reset still active after %0d cycles", n);
        timeouts++;
        break;
      end
      @(negedge clk);
      n++;
    end
  endtask

  // Called on a falling edge, returns on the falling edge after completion
  task automatic run_vector(input int base);
    logic [31:0] unit, op, opa, opb, opc, data, fw, lsu, br, exp_res, exp_br;
    int          stall;
    int          expect_low;
    int          low_cycles;
    logic        done;
    logic        high_op;
    logic        lsu_we;
    unit    = vec_mem[base];
    op      = vec_mem[base + 1];
    opa     = vec_mem[base + 2];
    opb     = vec_mem[base + 3];
    opc     = vec_mem[base + 4];
    data    = vec_mem[base + 5];
    fw      = vec_mem[base + 6];
    lsu     = vec_mem[base + 7];
    br      = vec_mem[base + 8];
    exp_res = vec_mem[base + 9];
    exp_br  = vec_mem[base + 10];
    // CSR rows also enable the ALU so the override is exercised
    alu_en_i            = (unit == 32'd0) || (unit == 32'd2);
    alu_operator_i      = alu_op_e'(op[3:0]);
    alu_operand_a_i     = opa;
    alu_operand_b_i     = opb;
    alu_operand_c_i     = opc;
    mult_en_i           = (unit == 32'd1);
    mult_operator_i     = mult_op_e'(op[1:0]);
    mult_operand_a_i    = opa;
    mult_operand_b_i    = opb;
    csr_access_i        = (unit == 32'd2);
    csr_rdata_i         = data;
    lsu_en_i            = (unit == 32'd3);
    lsu_rdata_i         = data;
    regfile_alu_we_i    = fw[5];
    regfile_alu_waddr_i = fw[4:0];
    lsu_err_i           = lsu[6];
    regfile_we_i        = lsu[5];
    regfile_waddr_i     = lsu[4:0];
    branch_in_ex_i      = br[0];
    stall               = $random(seed) & 3;
    // Branch rows always meet a stalled writeback
    if (br[0] && stall == 0) begin
      stall = 1;
    end
    wb_ready_i          = (stall == 0);
    high_op = (unit == 32'd1) && (op[1:0] != 2'd0);
    lsu_we  = lsu[5] & ~lsu[6];
    // Branch skips the stall, a high product needs at least two cycles
    if (br[0]) begin
      expect_low = 0;
    end else if (high_op && stall < 2) begin
      expect_low = 2;
    end else begin
      expect_low = stall;
    end
    low_cycles = 0;
    done       = 1'b0;
    while (!done && timeouts == 0) begin
      // Sample mid cycle, clear of both edges
      #2;
      if (ex_ready_o) begin
        done = 1'b1;
      end else begin
        if (!wb_ready_i) begin
          check_value("ex_valid_o while stalled", 32'(ex_valid_o), 32'h0);
        end
        if (high_op && low_cycles > 0) begin
          check_value("mult_multicycle_o while busy", 32'(mult_multicycle_o), 32'h1);
        end
        low_cycles++;
        if (low_cycles > READY_LIMIT) begin
          $display("Timeout: ex_ready_o stayed low for %0d cycles on vector %0d",
                   low_cycles, vec_count);
          timeouts++;
        end else begin
          @(negedge clk);
          wb_ready_i = (low_cycles >= stall);
        end
      end
    end
    if (timeouts == 0) begin
      check_value("cycles with ex_ready_o low", 32'(low_cycles), 32'(expect_low));
      if (unit != 32'd3) begin
        check_value("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, exp_res);
      end
      check_value("regfile_alu_we_fw_o", 32'(regfile_alu_we_fw_o), 32'(fw[5]));
      check_value("regfile_alu_waddr_fw_o", 32'(regfile_alu_waddr_fw_o), 32'(fw[4:0]));
      check_value("branch_decision_o", 32'(branch_decision_o), exp_br);
      check_value("jump_target_o", jump_target_o, opc);
      check_value("ex_valid_o", 32'(ex_valid_o), 32'(wb_ready_i));
      check_value("mult_multicycle_o", 32'(mult_multicycle_o), 32'(high_op));
      @(negedge clk);
      // LSU port shows up one edge later
      if (unit == 32'd3) begin
        check_value("regfile_we_wb_o", 32'(regfile_we_wb_o), 32'(lsu_we));
        if (lsu_we) begin
          check_value("regfile_waddr_wb_o", 32'(regfile_waddr_wb_o), 32'(lsu[4:0]));
          check_value("regfile_wdata_wb_o", regfile_wdata_wb_o, exp_res);
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    errors              = 0;
    checks              = 0;
    timeouts            = 0;
    vec_count           = 0;
    seed                = 32'h3c3467e8;
    alu_en_i            = 1'b0;
    alu_operator_i      = ALU_ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    mult_en_i           = 1'b0;
    mult_operator_i     = MUL;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    regfile_alu_we_i    = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    lsu_en_i            = 1'b0;
    lsu_rdata_i         = '0;
    lsu_ready_ex_i      = 1'b1;
    lsu_err_i           = 1'b0;
    branch_in_ex_i      = 1'b0;
    // Writeback stalled through reset, so only reset clears the LSU slot and the sequencer
    wb_ready_i          = 1'b0;
    $readmemh("verif/ex_vectors.txt", vec_mem);
    wait_reset();
    if (timeouts == 0) begin
      @(negedge clk);
      check_value("regfile_we_wb_o after reset", 32'(regfile_we_wb_o), 32'h0);
      check_value("mult_multicycle_o after reset", 32'(mult_multicycle_o), 32'h0);
    end
    // Unit code ff ends the list
    while (timeouts == 0 && vec_count < MAX_VECTORS &&
           vec_mem[vec_count*FIELDS] != 32'hff) begin
      run_vector(vec_count*FIELDS);
      vec_count++;
    end
    $display("Vectors: %0d, checks: %0d, errors: %0d, timeouts: %0d",
             vec_count, checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: src.f
source/ex_data_pkg.sv
source/ex_ops_pkg.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_writeback.sv
source/ex_stage_top.sv
verif/tb_clock_gen.sv
verif/tb_ex_stage.sv

// File: Makefile
# Verilator build and run of the execute stage testbench

SRCS := $(shell grep -v '^+' src.f)

.PHONY: all run check clean

all: check

# Rebuilt only when the file list or a source changes
obj_dir/Vtb_ex_stage: src.f $(SRCS)
	verilator --binary --assert --top-module tb_ex_stage -f src.f

run: obj_dir/Vtb_ex_stage
	./obj_dir/Vtb_ex_stage > sim.log 2>&1
	@cat sim.log

check: run
	@if grep -q "Errors found" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

// File: verif/ex_vectors.txt
// unit op a b c data fw lsu branch result flag, all hex, unit 0 alu 1 mult 2 csr 3 load
// fw is {we, addr[4:0]}, lsu is {err, we, addr[4:0]}, data is CSR or load data
0 0 7fffffff 00000001 00001000 00000000 21 00 0 80000000 0
0 0 ffffffff 00000002 00001004 00000000 22 00 0 00000001 0
0 1 00000000 00000001 00001008 00000000 23 00 0 ffffffff 0
0 2 f0f0f0f0 0ff00ff0 0000100c 00000000 24 00 0 00f000f0 0
0 3 f0f0f0f0 0ff00ff0 00001010 00000000 25 00 0 fff0fff0 0
0 4 f0f0f0f0 0ff00ff0 00001014 00000000 06 00 0 ff00ff00 0
0 5 00000001 0000001f 00001018 00000000 27 00 0 80000000 0
0 5 12345678 ffffffe0 0000101c 00000000 28 00 0 12345678 0
0 6 80000000 0000001f 00001020 00000000 29 00 0 00000001 0
0 7 80000000 0000001f 00001024 00000000 2a 00 0 ffffffff 0
0 7 80000000 00000004 00001028 00000000 2b 00 0 f8000000 0
0 8 ffffffff 00000001 0000102c 00000000 2c 00 0 00000001 0
0 9 ffffffff 00000001 00001030 00000000 2d 00 0 00000000 0
0 a 00000005 00000005 00001034 00000000 00 00 0 00000001 1
0 b 00000005 00000005 00001038 00000000 00 00 0 00000000 0
0 c 80000000 7fffffff 0000103c 00000000 00 00 0 00000001 1
0 e 80000000 7fffffff 00001040 00000000 00 00 0 00000000 0
0 d ffffffff 00000000 00001044 00000000 00 00 0 00000000 0
0 f ffffffff 00000000 00001048 00000000 00 00 0 00000001 1
0 a 00000003 00000003 80000100 00000000 00 00 1 00000001 1
0 c 00000001 00000002 80000200 00000000 00 00 1 00000001 1
1 0 00000003 fffffffe 00000000 00000000 3e 00 0 fffffffa 0
1 0 12345678 00010000 00000000 00000000 3e 00 0 56780000 0
1 1 ffffffff ffffffff 00000000 00000000 3f 00 0 00000000 0
1 3 ffffffff ffffffff 00000000 00000000 3f 00 0 fffffffe 0
1 2 ffffffff ffffffff 00000000 00000000 3f 00 0 ffffffff 0
1 1 80000000 80000000 00000000 00000000 3f 00 0 40000000 0
1 3 00010000 00010000 00000000 00000000 3f 00 0 00000001 0
1 1 7fffffff 80000000 00000000 00000000 3f 00 0 c0000000 0
2 0 00000001 00000002 00000000 0badc0de 2c 00 0 0badc0de 0
2 0 00000001 00000002 00000000 00000bad 05 00 0 00000bad 0
3 0 00000000 00000000 00000000 cafef00d 00 2a 0 cafef00d 0
3 0 00000000 00000000 00000000 cafef00d 00 6a 0 cafef00d 0
3 0 00000000 00000000 00000000 13579bdf 00 3f 0 13579bdf 0
ff 0 00000000 00000000 00000000 00000000 00 00 0 00000000 0
